// File: src/motion_box_consts.svh
`ifndef MOTION_BOX_CONSTS_SVH
`define MOTION_BOX_CONSTS_SVH

// ------------------------------------------------------------
// frame geometry
// ------------------------------------------------------------
`define FD_H_DISP      16       // active pixels per line
`define FD_V_DISP      8        // active lines per frame
`define FD_COORD_W     11       // wide enough for 1080p edges

// ------------------------------------------------------------
// luma and motion decision
// ------------------------------------------------------------
// weights sum to 256 so the luma is the top byte of the sum
`define FD_LUMA_R      77
`define FD_LUMA_G      150
`define FD_LUMA_B      29

`define FD_DIFF_THRESH 50       // motion if |diff| > this

`define FD_BOX_COLOR   24'hFF0000 // red rectangle

`endif

// File: src/motion_box_pkg.sv
`default_nettype none

`include "motion_box_consts.svh"

package motion_box_pkg;

  // red in the top byte, same packing as the 24-bit stream
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic vsync;
    logic hsync; // one-cycle pulse after the last pixel of a line
    logic valid;
  } vid_sync_t;

  typedef logic [`FD_COORD_W-1:0] coord_t;

  typedef struct packed {
    logic [7:0] cur;  // current frame
    logic [7:0] prev; // stored earlier frame
  } luma_pair_t;

  typedef struct packed {
    logic   found;
    coord_t top;
    coord_t bottom;
    coord_t left;
    coord_t right;
  } box_t;

endpackage

`default_nettype wire

// File: src/luma_convert.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module luma_convert
  import motion_box_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  vid_sync_t  in_sync,
  input  rgb_t       cur_pixel,
  input  rgb_t       ref_pixel,
  output vid_sync_t  out_sync,
  output luma_pair_t luma
);

  localparam int NPIX = 2; // index 0 current, 1 reference

  rgb_t        pix    [NPIX];
  logic [15:0] prod_q [NPIX][3];
  logic [15:0] sum    [NPIX];
  logic [7:0]  y_q    [NPIX];
  vid_sync_t   sync_q1;
  vid_sync_t   sync_q2;
  logic        cur_grey;

  assign pix[0] = cur_pixel;
  assign pix[1] = ref_pixel;

  // ------------------------------------------------------------
  // stage 1, weighted channels
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < NPIX; i++) begin
      prod_q[i][0] <= 16'(pix[i].r) * 16'(`FD_LUMA_R);
      prod_q[i][1] <= 16'(pix[i].g) * 16'(`FD_LUMA_G);
      prod_q[i][2] <= 16'(pix[i].b) * 16'(`FD_LUMA_B);
    end
  end

  // ------------------------------------------------------------
  // stage 2, sum and keep the top byte
  // ------------------------------------------------------------
  // max sum is 256 * 255, so 16 bits never overflow
  always_comb begin
    for (int i = 0; i < NPIX; i++) begin
      sum[i] = prod_q[i][0] + prod_q[i][1] + prod_q[i][2];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NPIX; i++) begin
      y_q[i] <= sum[i][15:8];
    end
  end

  // sync follows the two data stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= in_sync;
      sync_q2 <= sync_q1;
    end
  end

  assign out_sync = sync_q2;
  assign luma     = '{cur: y_q[0], prev: y_q[1]};

  assign cur_grey = (cur_pixel.r == cur_pixel.g) && (cur_pixel.g == cur_pixel.b);

  // a valid luma word carries the level of the grey pixel two cycles back
  a_luma_src_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_sync.valid && $past(cur_grey, 2) |-> luma.cur == $past(cur_pixel.r, 2)
  );

endmodule

`default_nettype wire

// File: src/frame_diff_threshold.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module frame_diff_threshold
  import motion_box_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  vid_sync_t  in_sync,
  input  luma_pair_t luma,
  output vid_sync_t  out_sync,
  output logic       motion
);

  logic [7:0] diff;
  logic       over;

  // absolute difference, no sign bit needed
  always_comb begin
    if (luma.cur > luma.prev) begin
      diff = luma.cur - luma.prev;
    end else begin
      diff = luma.prev - luma.cur;
    end
  end

  assign over = diff > 8'(`FD_DIFF_THRESH); // strictly greater

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_sync <= '0;
      motion   <= 1'b0;
    end else begin
      out_sync <= in_sync;
      motion   <= in_sync.valid && over; // blanking never counts
    end
  end

endmodule

`default_nettype wire

// File: src/pixel_position.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module pixel_position
  import motion_box_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  vid_sync_t sync,
  output coord_t    col,
  output coord_t    row
);

  // col/row hold the position of the pixel on the bus right now
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
      row <= '0;
    end else if (sync.vsync) begin
      col <= '0; // frame gap
      row <= '0;
    end else if (sync.hsync) begin
      col <= '0;
      row <= row + coord_t'(1);
    end else if (sync.valid) begin
      col <= col + coord_t'(1);
    end
  end

  // source must keep to the configured active area
  a_pos_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    sync.valid |-> (col < coord_t'(`FD_H_DISP)) && (row < coord_t'(`FD_V_DISP))
  );

endmodule

`default_nettype wire

// File: src/box_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module box_tracker
  import motion_box_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  vid_sync_t in_sync,
  input  logic      motion,
  output box_t      box
);

  coord_t col;
  coord_t row;
  box_t   work;     // box of the frame in flight
  logic   vsync_q;
  logic   vsync_rise;

  pixel_position pos_i (
    .clk   (clk),
    .rst_n (rst_n),
    .sync  (in_sync),
    .col   (col),
    .row   (row)
  );

  assign vsync_rise = in_sync.vsync && !vsync_q;

  // ------------------------------------------------------------
  // accumulate and publish
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vsync_q <= 1'b0;
      work    <= '0;
      box     <= '0;
    end else begin
      vsync_q <= in_sync.vsync;
      if (vsync_rise) begin
        box  <= work; // shown during the next frame
        work <= '0;
      end else if (motion) begin
        if (!work.found) begin
          // first hit seeds all four edges
          work.found  <= 1'b1;
          work.top    <= row;
          work.bottom <= row;
          work.left   <= col;
          work.right  <= col;
        end else begin
          if (row < work.top)    work.top    <= row;
          if (row > work.bottom) work.bottom <= row;
          if (col < work.left)   work.left   <= col;
          if (col > work.right)  work.right  <= col;
        end
      end
    end
  end

  a_box_ordered: assert property (
    @(posedge clk) disable iff (!rst_n)
    box.found |-> (box.top <= box.bottom) && (box.left <= box.right)
  );

endmodule

`default_nettype wire

// File: src/box_overlay.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module box_overlay
  import motion_box_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  vid_sync_t in_sync,
  input  rgb_t      in_pixel,
  input  box_t      box,
  output vid_sync_t out_sync,
  output rgb_t      out_pixel
);

  coord_t col;
  coord_t row;
  logic   in_rows;
  logic   in_cols;
  logic   on_hline;
  logic   on_vline;
  logic   draw;

  // position on the raw stream, not the delayed one
  pixel_position pos_i (
    .clk   (clk),
    .rst_n (rst_n),
    .sync  (in_sync),
    .col   (col),
    .row   (row)
  );

  // ------------------------------------------------------------
  // one-pixel border test
  // ------------------------------------------------------------
  assign in_rows  = (row >= box.top) && (row <= box.bottom);
  assign in_cols  = (col >= box.left) && (col <= box.right);
  assign on_hline = ((row == box.top) || (row == box.bottom)) && in_cols;
  assign on_vline = ((col == box.left) || (col == box.right)) && in_rows;

  assign draw = in_sync.valid && box.found && (on_hline || on_vline);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_sync  <= '0;
      out_pixel <= '0;
    end else begin
      out_sync <= in_sync;
      if (draw) begin
        out_pixel <= `FD_BOX_COLOR;
      end else begin
        out_pixel <= in_pixel; // interior and outside pass through
      end
    end
  end

endmodule

`default_nettype wire

// File: src/motion_box_top.sv
`timescale 1ns/1ps
`default_nettype none

module motion_box_top
  import motion_box_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  vid_sync_t in_sync,
  input  rgb_t      in_pixel,
  input  rgb_t      ref_pixel,  // co-located pixel of the stored frame
  output vid_sync_t out_sync,
  output rgb_t      out_pixel
);

  vid_sync_t  luma_sync;
  luma_pair_t luma;
  vid_sync_t  diff_sync;
  logic       motion;
  box_t       box;

  // ------------------------------------------------------------
  // detection path, 3 cycles deep
  // ------------------------------------------------------------
  luma_convert luma_convert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_sync   (in_sync),
    .cur_pixel (in_pixel),
    .ref_pixel (ref_pixel),
    .out_sync  (luma_sync),
    .luma      (luma)
  );

  frame_diff_threshold frame_diff_threshold_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_sync  (luma_sync),
    .luma     (luma),
    .out_sync (diff_sync),
    .motion   (motion)
  );

  box_tracker box_tracker_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_sync (diff_sync),
    .motion  (motion),
    .box     (box)
  );

  // ------------------------------------------------------------
  // drawing path, 1 cycle on the live stream
  // ------------------------------------------------------------
  box_overlay box_overlay_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_sync   (in_sync),
    .in_pixel  (in_pixel),
    .box       (box),
    .out_sync  (out_sync),
    .out_pixel (out_pixel)
  );

endmodule

`default_nettype wire

// File: dv/motion_box_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module motion_box_checker
  import motion_box_pkg::*;
#(
  parameter int NAME_W = 96
) (
  input  logic              clk,
  input  logic              rst_n,
  input  vid_sync_t         in_sync,
  input  rgb_t              in_pixel,
  input  vid_sync_t         out_sync,
  input  rgb_t              out_pixel,
  input  box_t              exp_box,    // box that belongs on the current frame
  input  logic [NAME_W-1:0] test_name,
  input  logic              run_done,
  input  int                frames_sent,
  output int                value_errors,
  output int                frame_errors
);

  int        col = 0;         // position of the pixel now on in_pixel
  int        row = 0;
  logic      armed = 1'b0;    // set once reset was seen
  vid_sync_t exp_sync_q;
  rgb_t      exp_pix_q;
  int        exp_col_q;
  int        exp_row_q;
  logic      on_border;
  logic      out_gap = 1'b0;
  logic      count_done = 1'b0;
  int        frames_seen = 0;
  int        n_value = 0;
  int        n_frame = 0;

  assign value_errors = n_value;
  assign frame_errors = n_frame;

  // one-pixel rectangle, edges inclusive
  always_comb begin
    on_border = 1'b0;
    if (in_sync.valid && exp_box.found) begin
      if ((row == int'(exp_box.top) || row == int'(exp_box.bottom)) &&
          col >= int'(exp_box.left) && col <= int'(exp_box.right)) begin
        on_border = 1'b1;
      end
      if ((col == int'(exp_box.left) || col == int'(exp_box.right)) &&
          row >= int'(exp_box.top) && row <= int'(exp_box.bottom)) begin
        on_border = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // output compare, one cycle behind the input
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (armed) begin
      if (out_sync !== exp_sync_q) begin
        $display("Fail %0s: out_sync expected %b, actual %b", test_name, exp_sync_q, out_sync);
        n_value++;
      end
      if (out_pixel !== exp_pix_q) begin
        $display("Fail %0s: pixel row %0d col %0d expected %h, actual %h",
                 test_name, exp_row_q, exp_col_q, exp_pix_q, out_pixel);
        n_value++;
      end
    end
    if (!rst_n) begin
      armed      <= 1'b1;
      exp_sync_q <= '0;  // outputs clear in reset
      exp_pix_q  <= '0;
      col        <= 0;
      row        <= 0;
    end else begin
      exp_sync_q <= in_sync;
      exp_pix_q  <= on_border ? `FD_BOX_COLOR : in_pixel;
      exp_col_q  <= col;
      exp_row_q  <= row;
      if (in_sync.vsync) begin
        col <= 0;
        row <= 0;
      end else if (in_sync.hsync) begin
        col <= 0;
        row <= row + 1;
      end else if (in_sync.valid) begin
        col <= col + 1;
      end
    end
  end

  // a frame counts at its first pixel after a vsync gap
  always @(posedge clk) begin
    if (!rst_n) begin
      out_gap <= 1'b0;
    end else if (out_sync.vsync) begin
      out_gap <= 1'b1;
    end else if (out_sync.valid && out_gap) begin
      out_gap <= 1'b0;
      frames_seen++;
    end
    if (run_done && !count_done) begin
      count_done <= 1'b1;
      if (frames_seen != frames_sent) begin
        $display("frame count wrong: %0d frames came out but %0d were sent",
                 frames_seen, frames_sent);
        n_frame++;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/motion_box_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "motion_box_consts.svh"

module motion_box_tb
  import motion_box_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int DRIVE_DLY  = 1;
  localparam int RST_CYC    = 8;
  localparam int LINE_CYC   = `FD_H_DISP + 3;  // pixels, hsync, 2 idle
  localparam int VSYNC_CYC  = 5;
  localparam int FRAME_CYC  = `FD_V_DISP * LINE_CYC + VSYNC_CYC;
  localparam int NSCEN      = 8;
  localparam int RUN_CYC    = RST_CYC + (NSCEN + 1) * FRAME_CYC + 8;
  localparam int NAME_W     = 8 * 12;

  localparam vid_sync_t SYNC_IDLE  = 3'b000;
  localparam vid_sync_t SYNC_VALID = 3'b001;
  localparam vid_sync_t SYNC_HS    = 3'b010;
  localparam vid_sync_t SYNC_VS    = 3'b100;

  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic [7:0]        base;      // grey level of the reference pixel
    coord_t            top;
    coord_t            bottom;
    coord_t            left;
    coord_t            right;
    logic              rect_en;
    logic [7:0]        delta;     // added to the current pixel where moving
    logic [7:0]        n_scatter;
  } scen_t;

  logic              clk;
  logic              rst_n;
  vid_sync_t         in_sync;
  rgb_t              in_pixel;
  rgb_t              ref_pixel;
  vid_sync_t         out_sync;
  rgb_t              out_pixel;
  box_t              shown_box;   // box expected on the frame now playing
  logic [NAME_W-1:0] shown_name;
  logic              run_done;
  int                value_errors;
  int                frame_errors;
  scen_t             scens [NSCEN];
  logic [7:0]        delta_map [`FD_V_DISP][`FD_H_DISP];
  int                seed;

  motion_box_top motion_box_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_sync   (in_sync),
    .in_pixel  (in_pixel),
    .ref_pixel (ref_pixel),
    .out_sync  (out_sync),
    .out_pixel (out_pixel)
  );

  motion_box_checker #(.NAME_W(NAME_W)) checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_sync      (in_sync),
    .in_pixel     (in_pixel),
    .out_sync     (out_sync),
    .out_pixel    (out_pixel),
    .exp_box      (shown_box),
    .test_name    (shown_name),
    .run_done     (run_done),
    .frames_sent  (NSCEN),
    .value_errors (value_errors),
    .frame_errors (frame_errors)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic scen_t make_scen(input logic [NAME_W-1:0] name, input int base,
                                      input int top, input int bottom, input int left,
                                      input int right, input int en, input int delta,
                                      input int scatter);
    scen_t s;
    s.name      = name;
    s.base      = 8'(base);
    s.top       = coord_t'(top);
    s.bottom    = coord_t'(bottom);
    s.left      = coord_t'(left);
    s.right     = coord_t'(right);
    s.rect_en   = 1'(en);
    s.delta     = 8'(delta);
    s.n_scatter = 8'(scatter);
    return s;
  endfunction

  // ------------------------------------------------------------
  // frame content and its expected box
  // ------------------------------------------------------------
  task automatic build_frame(input scen_t s);
    int rnd;
    int r;
    int c;
    for (int y = 0; y < `FD_V_DISP; y++) begin
      for (int x = 0; x < `FD_H_DISP; x++) begin
        delta_map[y][x] = 8'd0;
        if (s.rect_en && y >= s.top && y <= s.bottom && x >= s.left && x <= s.right) begin
          delta_map[y][x] = s.delta;
        end
      end
    end
    for (int k = 0; k < s.n_scatter; k++) begin
      rnd = $random(seed);
      r   = (rnd & 32'h7fff_ffff) % `FD_V_DISP;
      rnd = $random(seed);
      c   = (rnd & 32'h7fff_ffff) % `FD_H_DISP;
      delta_map[r][c] = s.delta;
    end
  endtask

  // grey pixels, so the luma difference is the delta itself
  function automatic box_t find_box();
    box_t b;
    b = '0;
    for (int y = 0; y < `FD_V_DISP; y++) begin
      for (int x = 0; x < `FD_H_DISP; x++) begin
        if (delta_map[y][x] > 8'(`FD_DIFF_THRESH)) begin
          if (!b.found || coord_t'(y) < b.top) b.top = coord_t'(y);
          if (!b.found || coord_t'(y) > b.bottom) b.bottom = coord_t'(y);
          if (!b.found || coord_t'(x) < b.left) b.left = coord_t'(x);
          if (!b.found || coord_t'(x) > b.right) b.right = coord_t'(x);
          b.found = 1'b1;
        end
      end
    end
    return b;
  endfunction

  // ------------------------------------------------------------
  // stream driver
  // ------------------------------------------------------------
  task automatic drive_cycle(input vid_sync_t s, input logic [7:0] cur, input logic [7:0] prev);
    @(posedge clk);
    #(DRIVE_DLY);
    in_sync   = s;
    in_pixel  = {cur, cur, cur};
    ref_pixel = {prev, prev, prev};
  endtask

  task automatic play_vsync();
    repeat (VSYNC_CYC) drive_cycle(SYNC_VS, 8'd0, 8'd0);
  endtask

  task automatic play_frame(input scen_t s);
    for (int y = 0; y < `FD_V_DISP; y++) begin
      for (int x = 0; x < `FD_H_DISP; x++) begin
        drive_cycle(SYNC_VALID, s.base + delta_map[y][x], s.base);
      end
      drive_cycle(SYNC_HS, 8'd0, 8'd0);
      repeat (2) drive_cycle(SYNC_IDLE, 8'd0, 8'd0);
    end
  endtask

  initial begin
    box_t prev_box;
    seed       = 47108;
    rst_n      = 1'b0;
    in_sync    = SYNC_IDLE;
    in_pixel   = '0;
    ref_pixel  = '0;
    run_done   = 1'b0;
    shown_box  = '0;
    shown_name = "reset";
    prev_box   = '0;
    scens[0] = make_scen("no_motion", 120, 0, 0, 0, 0, 0, 0, 0);
    scens[1] = make_scen("rect", 60, 2, 5, 3, 10, 1, 80, 0);
    scens[2] = make_scen("thresh_50", 100, 1, 6, 2, 12, 1, 50, 0);
    scens[3] = make_scen("thresh_51", 100, 3, 4, 5, 7, 1, 51, 0);
    scens[4] = make_scen("scatter", 90, 0, 0, 0, 0, 0, 70, 6);
    scens[5] = make_scen("single_px", 90, 4, 4, 9, 9, 1, 120, 0);
    scens[6] = make_scen("still_a", 30, 0, 0, 0, 0, 0, 0, 0);
    scens[7] = make_scen("still_b", 30, 0, 0, 0, 0, 0, 0, 0);
    repeat (RST_CYC) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    for (int i = 0; i < NSCEN; i++) begin
      play_vsync();
      shown_box  = prev_box;  // last frame's motion shows on this one
      shown_name = scens[i].name;
      build_frame(scens[i]);
      prev_box = find_box();
      play_frame(scens[i]);
    end
    play_vsync();
    repeat (4) drive_cycle(SYNC_IDLE, 8'd0, 8'd0);
    run_done = 1'b1;
    repeat (2) @(posedge clk);
    $display("errors: %0d value, %0d frame count", value_errors, frame_errors);
    if (value_errors == 0 && frame_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog, twice the length of the whole run
  initial begin
    #(2 * RUN_CYC * CLK_PERIOD);
    $display("run did not finish within %0d clock cycles", 2 * RUN_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: motion_box_top.f
+incdir+src
src/motion_box_pkg.sv
src/luma_convert.sv
src/frame_diff_threshold.sv
src/pixel_position.sv
src/box_tracker.sv
src/box_overlay.sv
src/motion_box_top.sv
dv/motion_box_checker.sv
dv/motion_box_tb.sv

// File: Bender.yml
package:
  name: motion_box

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/motion_box_pkg.sv
      - src/luma_convert.sv
      - src/frame_diff_threshold.sv
      - src/pixel_position.sv
      - src/box_tracker.sv
      - src/box_overlay.sv
      - src/motion_box_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/motion_box_checker.sv
      - dv/motion_box_tb.sv
